/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vkitchen_status_tb: flist.f $(wildcard logic/*.sv include/*.svh testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module kitchen_status_tb \
		-Mdir obj_dir -f flist.f

run: obj_dir/Vkitchen_status_tb
	./obj_dir/Vkitchen_status_tb +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	! grep -q "Test failed" sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* flist.f */
+incdir+include
logic/kitchen_pkg.sv
logic/button_debounce.sv
logic/round_keeper.sv
logic/status_receiver.sv
logic/status_arbiter.sv
logic/digit_scanner.sv
logic/kitchen_status_top.sv
testbench/kitchen_status_sva.sv
testbench/kitchen_status_checker.sv
testbench/kitchen_status_tb.sv

/* include/seg_font.svh */
// hex digit to segments, active high, segment a in bit 0
function automatic logic [6:0] hex_to_segments(input logic [3:0] value);
   logic [6:0] segments;
   case (value)
      4'h0: segments = 7'b011_1111;
      4'h1: segments = 7'b000_0110;
      4'h2: segments = 7'b101_1011;
      4'h3: segments = 7'b100_1111;
      4'h4: segments = 7'b110_0110;
      4'h5: segments = 7'b110_1101;
      4'h6: segments = 7'b111_1101;
      4'h7: segments = 7'b000_0111;
      4'h8: segments = 7'b111_1111;
      4'h9: segments = 7'b110_1111;
      4'hA: segments = 7'b111_0111;
      4'hB: segments = 7'b111_1100;
      4'hC: segments = 7'b011_1001;
      4'hD: segments = 7'b101_1110;
      4'hE: segments = 7'b111_1001;
      default: segments = 7'b111_0001;
   endcase
   return segments;
endfunction

/* logic/button_debounce.sv */
module button_debounce #(
   parameter int DEBOUNCE_CYCLES = 1_000_000
) (
   input  logic clk_in,
   input  logic reset_in,
   input  logic noisy,
   output logic clean
);

   localparam int COUNT_W = $clog2(DEBOUNCE_CYCLES + 1);

   logic [COUNT_W-1:0] stable_count;
   logic               last_sample;

   // count how long the input has held still, adopt it once long enough
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         last_sample  <= noisy;
         clean        <= noisy;
         stable_count <= '0;
      end else if (noisy != last_sample) begin
         // any change restarts the wait
         last_sample  <= noisy;
         stable_count <= '0;
      end else if (stable_count == COUNT_W'(DEBOUNCE_CYCLES)) begin
         clean <= last_sample;
      end else begin
         stable_count <= stable_count + 1'b1;
      end
   end

endmodule

/* logic/digit_scanner.sv */
module digit_scanner #(
   parameter int SCAN_CYCLES = 100_000
) (
   input  logic        clk_in,
   input  logic        reset_in,
   input  logic [31:0] digit_word,
   output logic [6:0]  seg_cathode,
   output logic [7:0]  seg_anode
);

   `include "seg_font.svh"

   localparam int DWELL_W = $clog2(SCAN_CYCLES + 1);

   logic [DWELL_W-1:0] dwell_count;
   logic               dwell_done;
   logic [7:0]         next_anode;
   logic [3:0]         next_nibble;

   assign dwell_done = (dwell_count == DWELL_W'(SCAN_CYCLES - 1));

   // anode that will be lit after this edge, so cathodes line up with it
   always_comb begin
      if (reset_in) begin
         next_anode = 8'b1111_1110;
      end else if (dwell_done) begin
         next_anode = {seg_anode[6:0], seg_anode[7]};
      end else begin
         next_anode = seg_anode;
      end
   end

   // route the nibble of the selected digit
   always_comb begin
      next_nibble = digit_word[3:0];
      for (int i = 0; i < 8; i++) begin
         if (!next_anode[i]) begin
            next_nibble = digit_word[i*4 +: 4];
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         dwell_count <= '0;
      end else if (dwell_done) begin
         dwell_count <= '0;
      end else begin
         dwell_count <= dwell_count + 1'b1;
      end
   end

   // both outputs active low
   always_ff @(posedge clk_in) begin
      seg_anode   <= next_anode;
      seg_cathode <= ~hex_to_segments(next_nibble);
   end

endmodule

/* logic/kitchen_pkg.sv */
package kitchen_pkg;

   ////////////////////////////////////////////////////////////
   // game state and status word
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      state_idle    = 2'd0,
      state_playing = 2'd1,
      state_over    = 2'd2
   } game_state_t;

   // laid out top bits first, as the primary console sends it
   typedef struct packed {
      game_state_t game_state;
      logic [13:0] point_total;
      logic [7:0]  time_left;
   } status_fields_t;

   // bytes[2] goes out on the wire first
   typedef union packed {
      logic [2:0][7:0] bytes;
      status_fields_t  fields;
   } status_word_u;

   ////////////////////////////////////////////////////////////
   // constants
   ////////////////////////////////////////////////////////////

   // opens every serial status frame
   localparam logic [7:0] status_sync_byte = 8'hA5;

   // score stops climbing here
   localparam logic [13:0] point_limit = 14'd9999;

endpackage

/* logic/kitchen_status_top.sv */
module kitchen_status_top import kitchen_pkg::*; #(
   parameter int DEBOUNCE_CYCLES   = 1_000_000,
   parameter int FRAMES_PER_SECOND = 60,
   parameter int ROUND_SECONDS     = 180,
   parameter int POINTS_PER_DISH   = 20,
   parameter int CLKS_PER_BIT      = 868,
   parameter int SCAN_CYCLES       = 100_000
) (
   input  logic           clk_in,
   input  logic           reset_in,
   input  logic           frame_in,
   input  logic           pause,
   input  logic           btn_chop,
   input  logic           serial_rx,
   input  logic [1:0]     player_id,
   output status_fields_t shown_status,
   output logic [6:0]     seg_cathode,
   output logic [7:0]     seg_anode
);

   logic           chop_clean;
   status_fields_t local_status;
   status_word_u   remote_status;
   logic           remote_valid;
   logic [31:0]    digit_word;

   ////////////////////////////////////////////////////////////
   // local round
   ////////////////////////////////////////////////////////////

   button_debounce #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) chop_debounce_i (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .noisy    (btn_chop),
      .clean    (chop_clean)
   );

   round_keeper #(
      .FRAMES_PER_SECOND (FRAMES_PER_SECOND),
      .ROUND_SECONDS     (ROUND_SECONDS),
      .POINTS_PER_DISH   (POINTS_PER_DISH)
   ) round_keeper_i (
      .clk_in       (clk_in),
      .reset_in     (reset_in),
      .frame_in     (frame_in),
      .pause        (pause),
      .chop         (chop_clean),
      .local_status (local_status)
   );

   // status broadcast from the primary console
   status_receiver #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) status_receiver_i (
      .clk_in        (clk_in),
      .reset_in      (reset_in),
      .serial_rx     (serial_rx),
      .remote_status (remote_status),
      .remote_valid  (remote_valid)
   );

   ////////////////////////////////////////////////////////////
   // selection and display
   ////////////////////////////////////////////////////////////

   status_arbiter status_arbiter_i (
      .clk_in        (clk_in),
      .reset_in      (reset_in),
      .frame_in      (frame_in),
      .player_id     (player_id),
      .local_status  (local_status),
      .remote_status (remote_status),
      .shown_status  (shown_status),
      .digit_word    (digit_word)
   );

   digit_scanner #(
      .SCAN_CYCLES (SCAN_CYCLES)
   ) digit_scanner_i (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .digit_word  (digit_word),
      .seg_cathode (seg_cathode),
      .seg_anode   (seg_anode)
   );

endmodule

/* logic/round_keeper.sv */
module round_keeper import kitchen_pkg::*; #(
   parameter int FRAMES_PER_SECOND = 60,
   parameter int ROUND_SECONDS     = 180,
   parameter int POINTS_PER_DISH   = 20
) (
   input  logic           clk_in,
   input  logic           reset_in,
   input  logic           frame_in,
   input  logic           pause,
   input  logic           chop,
   output status_fields_t local_status
);

   localparam int FRAME_W = $clog2(FRAMES_PER_SECOND + 1);

   logic               chop_prev;
   logic               chop_rise;
   logic               running;
   logic               second_tick;
   logic [FRAME_W-1:0] frame_count;
   logic [14:0]        point_sum;

   assign chop_rise   = chop & ~chop_prev;
   assign running     = (local_status.game_state == state_playing) & ~pause;
   assign second_tick = (frame_count == FRAME_W'(FRAMES_PER_SECOND - 1));

   // one spare bit so the saturation check sees the carry
   assign point_sum = {1'b0, local_status.point_total} + 15'(POINTS_PER_DISH);

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         chop_prev                <= chop;
         frame_count              <= '0;
         local_status.game_state  <= state_playing;
         local_status.point_total <= '0;
         local_status.time_left   <= 8'(ROUND_SECONDS);
      end else begin
         chop_prev <= chop;
         // score and clock both freeze while paused or over
         if (running) begin
            if (chop_rise) begin
               if (point_sum > {1'b0, point_limit}) begin
                  local_status.point_total <= point_limit;
               end else begin
                  local_status.point_total <= point_sum[13:0];
               end
            end
            if (frame_in) begin
               if (second_tick) begin
                  frame_count <= '0;
                  if (local_status.time_left <= 8'd1) begin
                     local_status.time_left  <= '0;
                     local_status.game_state <= state_over;
                  end else begin
                     local_status.time_left <= local_status.time_left - 8'd1;
                  end
               end else begin
                  frame_count <= frame_count + 1'b1;
               end
            end
         end
      end
   end

endmodule

/* logic/status_arbiter.sv */
module status_arbiter import kitchen_pkg::*; (
   input  logic           clk_in,
   input  logic           reset_in,
   input  logic           frame_in,
   input  logic [1:0]     player_id,
   input  status_fields_t local_status,
   input  status_word_u   remote_status,
   output status_fields_t shown_status,
   output logic [31:0]    digit_word
);

   // the primary shows its own round, everyone else follows the link
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         shown_status <= '0;
      end else if (frame_in) begin
         if (player_id == 2'd0) begin
            shown_status <= local_status;
         end else begin
            shown_status <= remote_status.fields;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // display word, top nibble first
   ////////////////////////////////////////////////////////////

   // player, state, four score nibbles, two timer nibbles
   assign digit_word = {
      2'b00, player_id,
      2'b00, shown_status.game_state,
      2'b00, shown_status.point_total,
      shown_status.time_left
   };

endmodule

/* logic/status_receiver.sv */
module status_receiver import kitchen_pkg::*; #(
   parameter int CLKS_PER_BIT = 868
) (
   input  logic         clk_in,
   input  logic         reset_in,
   input  logic         serial_rx,
   output status_word_u remote_status,
   output logic         remote_valid
);

   localparam int TIMER_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [TIMER_W-1:0] HALF_BIT = TIMER_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [TIMER_W-1:0] FULL_BIT = TIMER_W'(CLKS_PER_BIT - 1);

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   logic               rx_meta;
   logic               rx_sync;
   rx_state_t          rx_state;
   logic [TIMER_W-1:0] bit_timer;
   logic [2:0]         bit_count;
   logic [7:0]         shift_reg;
   // 0 while hunting for the sync byte, then status byte 1..3
   logic [1:0]         byte_count;
   status_word_u       frame_buf;

   // two flops in from the pin, idle line is high
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= serial_rx;
         rx_sync <= rx_meta;
      end
   end

   ////////////////////////////////////////////////////////////
   // bit timing and frame assembly
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         rx_state      <= rx_idle;
         bit_timer     <= '0;
         bit_count     <= '0;
         byte_count    <= '0;
         remote_valid  <= 1'b0;
         remote_status <= '0;
      end else begin
         remote_valid <= 1'b0;
         case (rx_state)
            rx_idle: begin
               if (!rx_sync) begin
                  rx_state  <= rx_start;
                  bit_timer <= '0;
               end
            end
            rx_start: begin
               // check the middle of the start bit, a glitch just goes back
               if (bit_timer == HALF_BIT) begin
                  bit_timer <= '0;
                  bit_count <= '0;
                  rx_state  <= rx_sync ? rx_idle : rx_data;
               end else begin
                  bit_timer <= bit_timer + 1'b1;
               end
            end
            rx_data: begin
               if (bit_timer == FULL_BIT) begin
                  bit_timer <= '0;
                  // lsb first
                  shift_reg <= {rx_sync, shift_reg[7:1]};
                  bit_count <= bit_count + 1'b1;
                  if (bit_count == 3'd7) begin
                     rx_state <= rx_stop;
                  end
               end else begin
                  bit_timer <= bit_timer + 1'b1;
               end
            end
            default: begin
               if (bit_timer == FULL_BIT) begin
                  bit_timer <= '0;
                  rx_state  <= rx_idle;
                  if (!rx_sync) begin
                     // framing error drops the whole frame
                     byte_count <= '0;
                  end else begin
                     case (byte_count)
                        2'd0: begin
                           if (shift_reg == status_sync_byte) begin
                              byte_count <= 2'd1;
                           end
                        end
                        2'd1: begin
                           frame_buf.bytes[2] <= shift_reg;
                           byte_count         <= 2'd2;
                        end
                        2'd2: begin
                           frame_buf.bytes[1] <= shift_reg;
                           byte_count         <= 2'd3;
                        end
                        default: begin
                           remote_status.bytes <= {frame_buf.bytes[2], frame_buf.bytes[1],
                                                   shift_reg};
                           remote_valid        <= 1'b1;
                           byte_count          <= 2'd0;
                        end
                     endcase
                  end
               end else begin
                  bit_timer <= bit_timer + 1'b1;
               end
            end
         endcase
      end
   end

endmodule

/* testbench/kitchen_status_checker.sv */
module kitchen_status_checker import kitchen_pkg::*; #(
   parameter int DEBOUNCE_CYCLES   = 4,
   parameter int FRAMES_PER_SECOND = 3,
   parameter int ROUND_SECONDS     = 6,
   parameter int POINTS_PER_DISH   = 20,
   parameter int CLKS_PER_BIT      = 8,
   parameter int SCAN_CYCLES       = 4
) (
   input  logic           clk_in,
   input  logic           reset_in,
   input  logic           frame_in,
   input  logic           pause,
   input  logic           btn_chop,
   input  logic           serial_rx,
   input  logic [1:0]     player_id,
   input  status_fields_t shown_status,
   input  logic [6:0]     seg_cathode,
   input  logic [7:0]     seg_anode,
   output int             error_count
);
   timeunit 1ns;
   timeprecision 1ps;

   `include "seg_font.svh"

   logic           deb_last;
   logic           deb_clean;
   int             deb_stable;
   logic           chop_prev;
   int             frame_ctr;
   int             point_sum;
   status_fields_t local_m;
   status_fields_t shown_m;
   logic [23:0]    remote_m = '0;
   int             digit;
   int             dwell;
   logic [31:0]    word;
   logic [6:0]     cathode_m;
   logic [7:0]     anode_m;
   logic           checking = 1'b0;
   int             mismatches = 0;

   assign error_count = mismatches;

   ////////////////////////////////////////////////////////////
   // cycle model of the local path and the display
   ////////////////////////////////////////////////////////////

   always @(posedge clk_in) begin
      // display word before this edge's update
      word = {2'b00, player_id, 2'b00, shown_m.game_state, 2'b00, shown_m.point_total,
              shown_m.time_left};
      if (reset_in) begin
         chop_prev = deb_clean;
         deb_clean = btn_chop;
         deb_last = btn_chop;
         deb_stable = 0;
         frame_ctr = 0;
         local_m = '{state_playing, 14'd0, 8'(ROUND_SECONDS)};
         shown_m = '0;
         digit = 0;
         dwell = 0;
         checking = 1'b1;
      end else begin
         if (dwell == SCAN_CYCLES - 1) begin
            dwell = 0;
            digit = (digit + 1) % 8;
         end else begin
            dwell++;
         end
         if (frame_in) begin
            shown_m = (player_id == 2'd0) ? local_m : status_fields_t'(remote_m);
         end
         if (local_m.game_state == state_playing && !pause) begin
            if (deb_clean && !chop_prev) begin
               point_sum = int'(local_m.point_total) + POINTS_PER_DISH;
               local_m.point_total = (point_sum > int'(point_limit)) ? point_limit
                                                                      : 14'(point_sum);
            end
            if (frame_in) begin
               frame_ctr++;
               if (frame_ctr == FRAMES_PER_SECOND) begin
                  frame_ctr = 0;
                  if (local_m.time_left <= 8'd1) begin
                     local_m.time_left = 8'd0;
                     local_m.game_state = state_over;
                  end else begin
                     local_m.time_left--;
                  end
               end
            end
         end
         chop_prev = deb_clean;
         // clean follows a level that held still long enough
         if (btn_chop != deb_last) begin
            deb_last = btn_chop;
            deb_stable = 0;
         end else if (deb_stable < DEBOUNCE_CYCLES) begin
            deb_stable++;
         end else begin
            deb_clean = deb_last;
         end
      end
      cathode_m = ~hex_to_segments(word[digit*4 +: 4]);
      anode_m = ~(8'b1 << digit);
   end

   // serial decode, mid-bit sampling, sync byte then three status bytes
   initial begin : serial_model
      logic [7:0]  rx_byte;
      logic [23:0] assembled;
      int          byte_idx;
      byte_idx = 0;
      assembled = '0;
      forever begin
         @(posedge clk_in);
         if (reset_in) begin
            byte_idx = 0;
         end else if (!serial_rx) begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk_in);
            if (!serial_rx) begin
               for (int b = 0; b < 8; b++) begin
                  repeat (CLKS_PER_BIT) @(posedge clk_in);
                  rx_byte[b] = serial_rx;
               end
               repeat (CLKS_PER_BIT) @(posedge clk_in);
               if (!serial_rx) begin
                  byte_idx = 0;
               end else if (byte_idx == 0) begin
                  byte_idx = (rx_byte == status_sync_byte) ? 1 : 0;
               end else begin
                  assembled = {assembled[15:0], rx_byte};
                  byte_idx++;
                  if (byte_idx == 4) begin
                     remote_m = assembled;
                     byte_idx = 0;
                  end
               end
            end
         end
      end
   end

   always @(negedge clk_in) begin
      if (checking && !reset_in) begin
         if (shown_status !== shown_m) begin
            mismatches++;
            $display("error: shown_status expected %h got %h", shown_m, shown_status);
         end
         if (seg_anode !== anode_m) begin
            mismatches++;
            $display("error: seg_anode expected %h got %h", anode_m, seg_anode);
         end
         if (seg_cathode !== cathode_m) begin
            mismatches++;
            $display("error: seg_cathode expected %h got %h", cathode_m, seg_cathode);
         end
      end
   end

endmodule

/* testbench/kitchen_status_sva.sv */
module kitchen_status_sva import kitchen_pkg::*; (
   input logic           clk_in,
   input logic           reset_in,
   input logic           frame_in,
   input status_fields_t shown_status,
   input logic [7:0]     seg_anode
);
   timeunit 1ns;
   timeprecision 1ps;

   int failure_count = 0;

   // exactly one digit lit
   anode_one_hot_low : assert property (
      @(posedge clk_in) disable iff (reset_in) $onehot(~seg_anode)
   ) else begin
      $error("more or fewer than one anode driven low");
      failure_count++;
   end

   // shown status only moves right after a strobe
   shown_after_strobe : assert property (
      @(posedge clk_in) disable iff (reset_in) !$stable(shown_status) |-> $past(frame_in)
   ) else begin
      $error("shown_status changed without a frame strobe");
      failure_count++;
   end

endmodule

// anode from the scanner, shown status from the arbiter
bind kitchen_status_top kitchen_status_sva kitchen_status_sva_i (
   .clk_in       (clk_in),
   .reset_in     (reset_in),
   .frame_in     (frame_in),
   .shown_status (shown_status),
   .seg_anode    (seg_anode)
);

/* testbench/kitchen_status_tb.sv */
module kitchen_status_tb import kitchen_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLKS_PER_BIT = 8;
   localparam int STROBE_EVERY = 60;
   // worst case length of every stimulus phase, in clock cycles
   localparam int STIMULUS_CYCLES = 16 + 10 * 70 + 400 + 1700 + 3 * 60 + 12 * 420 + 200;
   localparam int MARGIN_CYCLES = 2000;

   logic           clk_in;
   logic           reset_in;
   logic           frame_in;
   logic           pause;
   logic           btn_chop;
   logic           serial_rx;
   logic [1:0]     player_id;
   status_fields_t shown_status;
   logic [6:0]     seg_cathode;
   logic [7:0]     seg_anode;
   int             error_count;
   int             cycle = 0;
   logic           strobe_enable = 1'b0;
   logic [31:0]    lcg_state = 32'h00e50dab;

   kitchen_status_top #(
      .DEBOUNCE_CYCLES   (4),
      .FRAMES_PER_SECOND (3),
      .ROUND_SECONDS     (6),
      .POINTS_PER_DISH   (20),
      .CLKS_PER_BIT      (CLKS_PER_BIT),
      .SCAN_CYCLES       (4)
   ) kitchen_status_top_i (
      .clk_in       (clk_in),
      .reset_in     (reset_in),
      .frame_in     (frame_in),
      .pause        (pause),
      .btn_chop     (btn_chop),
      .serial_rx    (serial_rx),
      .player_id    (player_id),
      .shown_status (shown_status),
      .seg_cathode  (seg_cathode),
      .seg_anode    (seg_anode)
   );

   kitchen_status_checker #(
      .DEBOUNCE_CYCLES   (4),
      .FRAMES_PER_SECOND (3),
      .ROUND_SECONDS     (6),
      .POINTS_PER_DISH   (20),
      .CLKS_PER_BIT      (CLKS_PER_BIT),
      .SCAN_CYCLES       (4)
   ) checker_i (
      .clk_in       (clk_in),
      .reset_in     (reset_in),
      .frame_in     (frame_in),
      .pause        (pause),
      .btn_chop     (btn_chop),
      .serial_rx    (serial_rx),
      .player_id    (player_id),
      .shown_status (shown_status),
      .seg_cathode  (seg_cathode),
      .seg_anode    (seg_anode),
      .error_count  (error_count)
   );

   initial begin
      clk_in = 1'b0;
      forever #4 clk_in = ~clk_in;
   end

   // frame strobe every 60 cycles, once out of reset
   always @(posedge clk_in) begin
      cycle = cycle + 1;
      #1;
      frame_in = strobe_enable && (cycle % STROBE_EVERY == 0);
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int random_range(input int lo, input int hi);
      logic [31:0] r;
      r = next_random();
      return lo + int'(r[31:16]) % (hi - lo + 1);
   endfunction

   task automatic next_cycle();
      @(posedge clk_in);
      #1;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // keep button edges away from the strobe
   task automatic set_chop(input logic level);
      while (cycle % STROBE_EVERY < 4 || cycle % STROBE_EVERY > 56) begin
         next_cycle();
      end
      btn_chop = level;
   endtask

   task automatic press_chop(input int hold);
      set_chop(1'b1);
      wait_cycles(hold);
      set_chop(1'b0);
      wait_cycles(random_range(10, 20));
   endtask

   // 8N1, lsb first, stop bit sent low when stop_ok is 0
   task automatic send_byte(input logic [7:0] data, input logic stop_ok);
      serial_rx = 1'b0;
      wait_cycles(CLKS_PER_BIT);
      for (int b = 0; b < 8; b++) begin
         serial_rx = data[b];
         wait_cycles(CLKS_PER_BIT);
      end
      serial_rx = stop_ok;
      wait_cycles(CLKS_PER_BIT);
      serial_rx = 1'b1;
   endtask

   // data bytes never equal the sync byte, so a frame only lines up on a real sync
   function automatic logic [7:0] data_byte();
      logic [7:0] b;
      b = 8'(next_random() >> 8);
      if (b == status_sync_byte) begin
         b = b ^ 8'h01;
      end
      return b;
   endfunction

   task automatic send_frame(input int kind);
      logic [7:0] first;
      int         bad_index;
      first = (kind == 0) ? data_byte() : status_sync_byte;
      bad_index = (kind == 1) ? random_range(0, 3) : 4;
      // start so the frame ends well between strobes
      while (cycle % STROBE_EVERY != 20) begin
         next_cycle();
      end
      for (int i = 0; i < 4; i++) begin
         send_byte((i == 0) ? first : data_byte(), i != bad_index);
         if (i == bad_index) begin
            wait_cycles(2 * CLKS_PER_BIT);
            break;
         end
      end
      wait_cycles(CLKS_PER_BIT);
   endtask

   initial begin
      #((STIMULUS_CYCLES + MARGIN_CYCLES) * 8);
      $display("timeout: stimulus did not finish in time");
      $display("Test failed");
      $finish;
   end

   initial begin
      int failures;
      reset_in  = 1'b1;
      frame_in  = 1'b0;
      pause     = 1'b0;
      btn_chop  = 1'b0;
      serial_rx = 1'b1;
      player_id = 2'd0;
      wait_cycles(16);
      reset_in      = 1'b0;
      strobe_enable = 1'b1;

      ////////////////////////////////////////////////////////////
      // primary console, local round
      ////////////////////////////////////////////////////////////
      for (int i = 0; i < 10; i++) begin
         if (random_range(0, 3) == 0) begin
            // short glitch, must not score
            press_chop(random_range(1, 3));
         end else begin
            press_chop(random_range(10, 20));
         end
      end
      pause = 1'b1;
      press_chop(15);
      press_chop(12);
      wait_cycles(300);
      pause = 1'b0;
      // let the timer run out, then presses no longer count
      wait_cycles(1700);
      for (int i = 0; i < 3; i++) begin
         press_chop(random_range(10, 20));
      end

      ////////////////////////////////////////////////////////////
      // other console, status from the serial link
      ////////////////////////////////////////////////////////////
      set_chop(1'b0);
      player_id = 2'd2;
      for (int i = 0; i < 12; i++) begin
         send_frame(random_range(0, 4));
      end
      wait_cycles(2 * STROBE_EVERY + 10);

      failures = kitchen_status_top_i.kitchen_status_sva_i.failure_count;
      $display("checker errors: %0d, assertion failures: %0d", error_count, failures);
      if (error_count == 0 && failures == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
